/* Makefile */
# Verilator build and run for the DRO subsystem testbench

SIM := obj_dir/Vdro_tb
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): files.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module dro_tb -f files.f -o Vdro_tb

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

/* files.f */
verilog/dro_pkg.sv
verilog/dro_report_if.sv
verilog/dro_input_filter.sv
verilog/dro_frame_decoder.sv
verilog/dro_reporter.sv
verilog/dro_top.sv
sim/dro_tb.sv

/* sim/dro_stimulus.txt */
# CFG   channel timeout(cycles) mode(0 param, 1 daq)
# FRAME channel bits value(hex) half_period style(0 clean, 1 data glitch, 2 clock low) path
# GAP   idle cycles
CFG 0 600 0
CFG 1 600 1
CFG 2 600 0
CFG 3 0 0
GAP 50
# parameter reports and duplicate suppression
FRAME 0 8 a5 200 0 param
GAP 4500
FRAME 0 8 a5 200 0 none
GAP 4500
FRAME 0 8 a4 200 0 param
GAP 4500
FRAME 0 12 0a4 200 0 param
GAP 6000
# daq records, same frame twice
FRAME 1 10 2c3 200 0 daq
GAP 5000
FRAME 1 10 2c3 200 0 daq
GAP 5000
# disabled channel
FRAME 3 8 5a 200 0 none
GAP 4500
# glitch, abort, then a normal frame
FRAME 2 16 beef 200 1 param
GAP 7500
FRAME 2 8 00 200 2 none
GAP 2000
FRAME 2 8 3c 200 0 param
GAP 4500
# arbitration, frames listed lowest channel first
FRAME 0 8 22 200 0 param
FRAME 2 8 11 200 0 param
GAP 4500
FRAME 0 8 44 200 0 param
FRAME 1 8 33 200 0 daq
GAP 4500

/* sim/dro_tb.sv */
`timescale 1ns/1ps

module dro_tb;
	import dro_pkg::*;

	localparam int FRAME_MARGIN = 1000;	// decoder timeout plus report, per frame
	localparam int DRAIN_CYCLES = 400;
	localparam int GLITCH_CYCLES = DEBOUNCE_CYCLES / 2;

	logic clk = 1'b0;
	logic rst_n;
	word_t systime = '0;
	cmd_t cmd;
	logic cmd_ready;
	word_t arg_data;
	logic cmd_done;
	param_t param_data;
	logic param_write;
	logic invol_req;
	logic invol_grant;
	word_t daq_data;
	logic daq_valid;
	logic daq_end;
	logic daq_req;
	logic daq_grant;
	logic [DRO_CHANNELS-1:0] dro_clk;
	logic [DRO_CHANNELS-1:0] dro_do;

	int cycles = 0;
	int limit = 0;
	int error_count = 0;
	logic [15:0] lfsr = 16'd47738;

	// a grant given and not yet used by a report
	logic invol_granted = 1'b0;
	logic daq_granted = 1'b0;

	// reference model of the per channel config and duplicate rule
	int cfg_timeout [DRO_CHANNELS];
	logic cfg_mode [DRO_CHANNELS];
	logic seen [DRO_CHANNELS];
	word_t prev_data [DRO_CHANNELS];
	int prev_bits [DRO_CHANNELS];

	// reports still owed by the DUT, oldest first
	string exp_path [$];
	channel_t exp_chan [$];
	word_t exp_t0 [$];
	word_t exp_data [$];
	bitcount_t exp_bits [$];

	// parsed stimulus, kind 0 cfg, 1 frame, 2 gap
	int op_kind [$];
	int op_a [$];
	int op_b [$];
	int op_c [$];
	int op_half [$];
	int op_style [$];
	word_t op_val [$];
	string op_path [$];

	dro_top dut_i (
		.clk (clk),
		.rst_n (rst_n),
		.systime (systime),
		.cmd (cmd),
		.cmd_ready (cmd_ready),
		.arg_data (arg_data),
		.cmd_done (cmd_done),
		.param_data (param_data),
		.param_write (param_write),
		.invol_req (invol_req),
		.invol_grant (invol_grant),
		.daq_data (daq_data),
		.daq_valid (daq_valid),
		.daq_end (daq_end),
		.daq_req (daq_req),
		.daq_grant (daq_grant),
		.dro_clk (dro_clk),
		.dro_do (dro_do)
	);

	always #4 clk = ~clk;

	always @(negedge clk) systime <= systime + 1;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// ======================================================================
	// failure reporting and compare tasks
	// ======================================================================
	task automatic value_error(input string msg);
		error_count++;
		$display("Error at %0t ns: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic plain_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run failed");
	endtask

	function automatic int draw_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};	// x^16+x^14+x^13+x^11+1
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic compare_cmd(input cmd_t code, input int got, input int exp);
		if (got != exp)
			value_error($sformatf("command %02h gave cmd_done after %0d cycles, expected %0d",
				code, got, exp));
	endtask

	task automatic pop_expected(input string path, output channel_t ch, output word_t t0,
			output word_t data, output bitcount_t bits);
		string p;
		if (exp_path.size() == 0)
			plain_failure($sformatf("a %s report arrived while no frame was pending", path));
		p = exp_path.pop_front();
		ch = exp_chan.pop_front();
		t0 = exp_t0.pop_front();
		data = exp_data.pop_front();
		bits = exp_bits.pop_front();
		if (p != path)
			value_error($sformatf("got a %s report for channel %0d, expected %s", path, ch, p));
	endtask

	task automatic check_start(input word_t got, input word_t t0);
		if (got < t0 || got > t0 + FILTER_LATENCY + 1)
			value_error($sformatf("starttime %0d outside %0d..%0d", got, t0,
				t0 + FILTER_LATENCY + 1));
	endtask

	task automatic compare_param_report(input channel_t ch, input word_t start,
			input word_t data, input bitcount_t bits);
		channel_t e_ch;
		word_t e_t0;
		word_t e_data;
		bitcount_t e_bits;
		pop_expected("param", e_ch, e_t0, e_data, e_bits);
		if (ch != e_ch)
			value_error($sformatf("param channel %0d, expected %0d", ch, e_ch));
		check_start(start, e_t0);
		if (data != e_data)
			value_error($sformatf("param data %08h, expected %08h", data, e_data));
		if (bits != e_bits)
			value_error($sformatf("param bit count %0d, expected %0d", bits, e_bits));
	endtask

	task automatic compare_daq_record(input word_t header, input word_t data,
			input word_t start, input logic [2:0] ends);
		channel_t e_ch;
		word_t e_t0;
		word_t e_data;
		bitcount_t e_bits;
		pop_expected("daq", e_ch, e_t0, e_data, e_bits);
		if (header != {DAQT_DRO_DATA, 8'(e_ch), 16'h0000})
			value_error($sformatf("daq header %08h for channel %0d", header, e_ch));
		if (data != e_data)
			value_error($sformatf("daq data %08h, expected %08h", data, e_data));
		check_start(start, e_t0);
		if (ends != 3'b100)
			value_error($sformatf("daq_end pattern %03b, expected 100", ends));
	endtask

	// ======================================================================
	// bus responders and monitors
	// ======================================================================
	initial begin : invol_responder
		int d;
		invol_grant = 1'b0;
		forever begin
			@(negedge clk);
			if (invol_req) begin
				d = draw_bits(3);
				repeat (d) begin
					@(negedge clk);
					if (!invol_req)
						plain_failure("invol_req dropped before its grant");
				end
				invol_grant = 1'b1;
				invol_granted = 1'b1;
				@(negedge clk);
				invol_grant = 1'b0;
			end
		end
	end

	initial begin : daq_responder
		int d;
		daq_grant = 1'b0;
		forever begin
			@(negedge clk);
			if (daq_req) begin
				d = draw_bits(3);
				repeat (d) begin
					@(negedge clk);
					if (!daq_req)
						plain_failure("daq_req dropped before its grant");
				end
				daq_grant = 1'b1;
				daq_granted = 1'b1;
				@(negedge clk);
				daq_grant = 1'b0;
			end
		end
	end

	initial begin : param_monitor
		word_t w [4];
		forever begin
			@(negedge clk);
			if (param_write) begin
				if (!invol_granted)
					plain_failure("parameter report started without invol_grant");
				invol_granted = 1'b0;
				for (int k = 0; k < 4; k++) begin
					if (!param_write)
						plain_failure("param_write dropped before the fourth response word");
					w[k] = param_data[31:0];
					@(negedge clk);
				end
				if (param_write || param_data != param_t'(RSP_DRO_DATA) || !cmd_done)
					value_error("response not closed by RSP_DRO_DATA with cmd_done");
				compare_param_report(channel_t'(w[0]), w[1], w[2], bitcount_t'(w[3]));
			end
		end
	end

	initial begin : daq_monitor
		word_t w [3];
		logic [2:0] ends;
		forever begin
			@(negedge clk);
			if (daq_valid) begin
				if (!daq_granted)
					plain_failure("daq record started without daq_grant");
				daq_granted = 1'b0;
				for (int k = 0; k < 3; k++) begin
					if (!daq_valid)
						plain_failure("daq_valid dropped inside a record");
					w[k] = daq_data;
					ends[k] = daq_end;
					@(negedge clk);
				end
				compare_daq_record(w[0], w[1], w[2], ends);
			end
		end
	end

	// ======================================================================
	// scale model, command driver and stimulus
	// ======================================================================
	task automatic send_frame(input int ch, input int nbits, input word_t value,
			input int half, input int style, input int hold);
		if (style == 2) begin
			dro_clk[ch] = 1'b0;	// clock stuck low past the timeout
			wait_cycles(hold);
			dro_clk[ch] = 1'b1;
			wait_cycles(half);
		end else begin
			for (int i = nbits - 1; i >= 0; i--) begin
				dro_clk[ch] = 1'b0;
				dro_do[ch] = value[i];
				if (style == 1 && i == nbits - 1) begin
					// data glitch straddles the rising clock edge
					wait_cycles(half - GLITCH_CYCLES / 2);
					dro_do[ch] = !value[i];
					wait_cycles(GLITCH_CYCLES / 2);
					dro_clk[ch] = 1'b1;
					wait_cycles(GLITCH_CYCLES - GLITCH_CYCLES / 2);
					dro_do[ch] = value[i];
					wait_cycles(half - (GLITCH_CYCLES - GLITCH_CYCLES / 2));
				end else begin
					wait_cycles(half);
					dro_clk[ch] = 1'b1;
					wait_cycles(half);
				end
			end
		end
		dro_do[ch] = 1'b1;
	endtask

	task automatic start_frame(input int ch, input int nbits, input word_t value,
			input int half, input int style, input string path);
		word_t masked;
		string ref_path;
		logic changed;
		masked = (nbits >= 32) ? value : value & ((32'd1 << nbits) - 1);
		changed = !seen[ch] || masked != prev_data[ch] || nbits != prev_bits[ch] || cfg_mode[ch];
		ref_path = "none";
		if (cfg_timeout[ch] != 0 && style != 2) begin
			if (changed)
				ref_path = cfg_mode[ch] ? "daq" : "param";
			seen[ch] = 1'b1;
			prev_data[ch] = masked;
			prev_bits[ch] = nbits;
		end
		if (ref_path != path)
			plain_failure($sformatf("stimulus says %s for channel %0d, model expects %s",
				path, ch, ref_path));
		if (ref_path != "none") begin
			exp_path.push_back(ref_path);
			exp_chan.push_back(channel_t'(ch));
			exp_t0.push_back(systime);
			exp_data.push_back(masked);
			exp_bits.push_back(bitcount_t'(nbits));
		end
		fork
			send_frame(ch, nbits, value, half, style, cfg_timeout[ch] + 100);
		join_none
	endtask

	task automatic run_command(input cmd_t code, input word_t a0, input word_t a1,
			input word_t a2, input int exp_lat);
		int got;
		got = 0;
		cmd = code;
		cmd_ready = 1'b1;
		arg_data = a0;	// first argument rides with the strobe
		for (int k = 1; k <= 8 && got == 0; k++) begin
			@(negedge clk);
			cmd_ready = 1'b0;
			arg_data = (k == 1) ? a1 : (k == 2) ? a2 : '0;
			if (cmd_done)
				got = k;
		end
		compare_cmd(code, got, exp_lat);
	endtask

	task automatic read_stimulus();
		int fd;
		int n;
		int a;
		int b;
		int c;
		int d;
		int e;
		word_t v;
		string line;
		string kind;
		string path;
		fd = $fopen("sim/dro_stimulus.txt", "r");
		if (fd == 0)
			plain_failure("cannot open sim/dro_stimulus.txt");
		while (!$feof(fd)) begin
			line = "";
			kind = "";
			n = $fgets(line, fd);
			if (n > 0)
				n = $sscanf(line, "%s", kind);
			if (kind == "CFG") begin
				n = $sscanf(line, "%s %d %d %d", kind, a, b, c);
				op_kind.push_back(0);
				op_a.push_back(a);
				op_b.push_back(b);
				op_c.push_back(c);
				op_half.push_back(0);
				op_style.push_back(0);
				op_val.push_back('0);
				op_path.push_back("");
				limit += 16;
			end else if (kind == "FRAME") begin
				n = $sscanf(line, "%s %d %d %h %d %d %s", kind, a, b, v, d, e, path);
				op_kind.push_back(1);
				op_a.push_back(a);
				op_b.push_back(b);
				op_c.push_back(0);
				op_half.push_back(d);
				op_style.push_back(e);
				op_val.push_back(v);
				op_path.push_back(path);
				limit += b * 2 * d + FRAME_MARGIN;
			end else if (kind == "GAP") begin
				n = $sscanf(line, "%s %d", kind, a);
				op_kind.push_back(2);
				op_a.push_back(a);
				op_b.push_back(0);
				op_c.push_back(0);
				op_half.push_back(0);
				op_style.push_back(0);
				op_val.push_back('0);
				op_path.push_back("");
				limit += a;
			end
		end
		$fclose(fd);
	endtask

	initial begin : main
		int total;
		rst_n = 1'b0;
		cmd = '0;
		cmd_ready = 1'b0;
		arg_data = '0;
		dro_clk = '1;	// idle scale lines are high
		dro_do = '1;
		for (int i = 0; i < DRO_CHANNELS; i++) begin
			cfg_timeout[i] = 0;
			cfg_mode[i] = 1'b0;
			seen[i] = 1'b0;
			prev_data[i] = '0;
			prev_bits[i] = 0;
		end
		read_stimulus();
		total = limit + 16 + 100 + DRAIN_CYCLES;
		limit = total;

		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		wait_cycles(4);
		if (cmd_done || param_write || invol_req || daq_req || daq_valid || daq_end)
			value_error("outputs not low after reset");

		run_command(8'h7e, '0, '0, '0, 1);	// unknown code

		for (int i = 0; i < op_kind.size(); i++) begin
			case (op_kind[i])
			0: begin
				run_command(CMD_CONFIG_DRO, word_t'(op_a[i]), word_t'(op_b[i]),
					word_t'(op_c[i]), 3);
				cfg_timeout[op_a[i]] = op_b[i];
				cfg_mode[op_a[i]] = op_c[i][0];
			end
			1: start_frame(op_a[i], op_b[i], op_val[i], op_half[i], op_style[i], op_path[i]);
			default: wait_cycles(op_a[i]);
			endcase
		end

		while (exp_path.size() > 0)
			@(negedge clk);
		wait_cycles(DRAIN_CYCLES);	// catch stray reports

		if (error_count == 0 && exp_path.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* verilog/dro_frame_decoder.sv */
`timescale 1ns/1ps

module dro_frame_decoder (
	input logic clk,
	input logic rst_n,
	input dro_pkg::word_t systime,
	input logic clk_f,
	input logic do_f,
	input dro_pkg::timeout_t timeout,
	input logic report_all,
	dro_report_if.decoder rpt
);
	import dro_pkg::*;

	frame_state_t state;
	timeout_t tcnt;

	word_t shift;
	bitcount_t nbits;
	word_t start_q;
	word_t prev_data;
	bitcount_t prev_bits;

	logic enabled;
	logic frame_start;
	logic bit_in;
	logic changed;

	assign enabled = (timeout != '0);	// zero timeout switches the channel off
	assign frame_start = enabled && (state == FS_IDLE) && !clk_f;
	assign bit_in = enabled && (state == FS_CLK_LO) && clk_f;
	assign changed = (shift != prev_data) || (nbits != prev_bits) || report_all;

	// frame payload, stable from frame end until the next frame starts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift <= '0;
			nbits <= '0;
			start_q <= '0;
		end else if (frame_start) begin
			shift <= '0;
			nbits <= '0;
			start_q <= systime;
		end else if (bit_in) begin
			shift <= {shift[30:0], do_f};	// msb first
			if (nbits != bitcount_t'(32))
				nbits <= nbits + 1'b1;
		end
	end

	// ======================================================================
	// frame state machine
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FS_IDLE;
			tcnt <= '0;
			rpt.valid <= 1'b0;
			prev_data <= '1;
			prev_bits <= '0;	// no real frame has zero bits
		end else if (!enabled) begin
			state <= FS_IDLE;
			tcnt <= '0;
			rpt.valid <= 1'b0;
		end else begin
			if (tcnt != '0)
				tcnt <= tcnt - 1'b1;
			if (rpt.ack)
				rpt.valid <= 1'b0;

			case (state)
			FS_IDLE: begin
				if (!clk_f) begin
					rpt.valid <= 1'b0;	// an unreported frame is lost here
					tcnt <= timeout;
					state <= FS_CLK_LO;
				end
			end
			FS_CLK_LO: begin
				if (clk_f) begin
					tcnt <= timeout;
					state <= FS_CLK_HI;
				end else if (tcnt == timeout_t'(1)) begin
					tcnt <= '0;
					state <= FS_WAIT_HI;	// clock stuck low, abort
				end
			end
			FS_CLK_HI: begin
				if (!clk_f) begin
					tcnt <= timeout;
					state <= FS_CLK_LO;
				end else if (tcnt == timeout_t'(1)) begin
					if (changed)
						rpt.valid <= 1'b1;
					prev_data <= shift;
					prev_bits <= nbits;
					tcnt <= '0;
					state <= FS_IDLE;
				end
			end
			FS_WAIT_HI: begin
				if (clk_f)
					state <= FS_IDLE;
			end
			default: state <= FS_IDLE;
			endcase
		end
	end

	assign rpt.data = shift;
	assign rpt.bits = nbits;
	assign rpt.starttime = start_q;

endmodule

/* verilog/dro_input_filter.sv */
`timescale 1ns/1ps

module dro_input_filter (
	input logic clk,
	input logic rst_n,
	input logic dro_clk,
	input logic dro_do,
	output logic clk_f,
	output logic do_f
);
	import dro_pkg::*;

	// bit 1 is the scale clock, bit 0 the data wire
	logic [1:0] sync1;
	logic [1:0] sync2;
	logic [1:0] level;
	debounce_t cnt [2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '1;	// idle lines sit high
			sync2 <= '1;
			level <= '1;
			for (int i = 0; i < 2; i++) begin
				cnt[i] <= debounce_t'(DEBOUNCE_CYCLES);
			end
		end else begin
			sync1 <= {dro_clk, dro_do};
			sync2 <= sync1;

			// a new level has to hold for the whole count
			for (int i = 0; i < 2; i++) begin
				if (sync2[i] == level[i]) begin
					cnt[i] <= debounce_t'(DEBOUNCE_CYCLES);	// glitch gone, start over
				end else if (cnt[i] == debounce_t'(1)) begin
					level[i] <= sync2[i];
					cnt[i] <= debounce_t'(DEBOUNCE_CYCLES);
				end else begin
					cnt[i] <= cnt[i] - 1'b1;
				end
			end
		end
	end

	assign clk_f = level[1];
	assign do_f = level[0];

endmodule

/* verilog/dro_pkg.sv */
package dro_pkg;

	// ======================================================================
	// sizes and timing
	// ======================================================================
	localparam int DRO_CHANNELS = 4;
	localparam int CHANNEL_BITS = (DRO_CHANNELS > 1) ? $clog2(DRO_CHANNELS) : 1;

	localparam int CLK_HZ = 125_000_000;
	localparam int DEBOUNCE_CYCLES = CLK_HZ / 1_000_000;	// 1 us
	localparam int DEBOUNCE_BITS = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int FILTER_LATENCY = DEBOUNCE_CYCLES + 2;	// sync stages plus debounce

	localparam int TIMEOUT_BITS = $clog2(CLK_HZ);	// up to one second
	localparam int CMD_BITS = 8;

	// ======================================================================
	// command, response and record codes
	// ======================================================================
	localparam logic [CMD_BITS-1:0] CMD_CONFIG_DRO = 8'h30;
	localparam logic [7:0] RSP_DRO_DATA = 8'h31;
	localparam logic [7:0] DAQT_DRO_DATA = 8'd48;

	typedef logic [CHANNEL_BITS-1:0] channel_t;
	typedef logic [31:0] word_t;
	typedef logic [5:0] bitcount_t;	// 0 to 32 bits per frame
	typedef logic [TIMEOUT_BITS-1:0] timeout_t;
	typedef logic [CMD_BITS-1:0] cmd_t;
	typedef logic [32:0] param_t;
	typedef logic [DEBOUNCE_BITS-1:0] debounce_t;

	// ======================================================================
	// state machines
	// ======================================================================
	typedef enum logic [1:0] {
		FS_IDLE,
		FS_CLK_LO,
		FS_CLK_HI,
		FS_WAIT_HI	// aborted frame, wait for the clock to return high
	} frame_state_t;

	typedef enum logic [3:0] {
		IDLE,
		CFG_TIMEOUT,
		CFG_MODE,
		WAIT_GRANT,
		PRM_CHANNEL,
		PRM_TIME,
		PRM_DATA,
		PRM_BITS,
		PRM_DONE,
		DAQ_HEADER,
		DAQ_DATA,
		DAQ_TIME
	} rpt_state_t;

endpackage

/* verilog/dro_report_if.sv */
`timescale 1ns/1ps

// one finished frame, held until acked
interface dro_report_if;
	import dro_pkg::*;

	logic valid;
	word_t data;
	bitcount_t bits;
	word_t starttime;
	logic ack;	// one cycle, valid drops on the next edge

	modport decoder (
		output valid,
		output data,
		output bits,
		output starttime,
		input ack
	);

	modport reporter (
		input valid,
		input data,
		input bits,
		input starttime,
		output ack
	);

endinterface

/* verilog/dro_reporter.sv */
`timescale 1ns/1ps

module dro_reporter (
	input logic clk,
	input logic rst_n,

	input dro_pkg::cmd_t cmd,
	input logic cmd_ready,
	input dro_pkg::word_t arg_data,
	output logic cmd_done,

	output dro_pkg::param_t param_data,
	output logic param_write,
	output logic invol_req,
	input logic invol_grant,

	output dro_pkg::word_t daq_data,
	output logic daq_valid,
	output logic daq_end,
	output logic daq_req,
	input logic daq_grant,

	output dro_pkg::timeout_t timeout [dro_pkg::DRO_CHANNELS],
	output logic [dro_pkg::DRO_CHANNELS-1:0] report_all,

	dro_report_if.reporter rpt [dro_pkg::DRO_CHANNELS]
);
	import dro_pkg::*;

	rpt_state_t state;
	channel_t chan;	// channel being configured or reported
	channel_t pick;
	logic [DRO_CHANNELS-1:0] ack_q;

	logic [DRO_CHANNELS-1:0] valid_v;
	word_t data_v [DRO_CHANNELS];
	bitcount_t bits_v [DRO_CHANNELS];
	word_t start_v [DRO_CHANNELS];

	for (genvar i = 0; i < DRO_CHANNELS; i++) begin : g_port
		assign valid_v[i] = rpt[i].valid;
		assign data_v[i] = rpt[i].data;
		assign bits_v[i] = rpt[i].bits;
		assign start_v[i] = rpt[i].starttime;
		assign rpt[i].ack = ack_q[i];
	end

	// lowest pending channel wins
	always_comb begin
		pick = '0;
		for (int i = DRO_CHANNELS - 1; i >= 0; i--) begin
			if (valid_v[i])
				pick = channel_t'(i);
		end
	end

	// ======================================================================
	// command and report sequencer
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			chan <= '0;
			cmd_done <= 1'b0;
			param_write <= 1'b0;
			invol_req <= 1'b0;
			daq_req <= 1'b0;
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
			ack_q <= '0;
			report_all <= '0;
			for (int i = 0; i < DRO_CHANNELS; i++) begin
				timeout[i] <= '0;
			end
		end else begin
			cmd_done <= 1'b0;
			ack_q <= '0;
			daq_valid <= 1'b0;
			daq_end <= 1'b0;

			case (state)
			IDLE: begin
				if (cmd_ready) begin
					chan <= arg_data[CHANNEL_BITS-1:0];	// first arg is the channel
					if (cmd == CMD_CONFIG_DRO)
						state <= CFG_TIMEOUT;
					else
						cmd_done <= 1'b1;
				end else if (|valid_v) begin
					chan <= pick;
					if (report_all[pick])
						daq_req <= 1'b1;
					else
						invol_req <= 1'b1;
					state <= WAIT_GRANT;
				end
			end
			CFG_TIMEOUT: begin
				timeout[chan] <= arg_data[TIMEOUT_BITS-1:0];
				state <= CFG_MODE;
			end
			CFG_MODE: begin
				report_all[chan] <= arg_data[0];
				cmd_done <= 1'b1;
				state <= IDLE;
			end
			WAIT_GRANT: begin
				// mode cannot change here, commands are blocked
				if (report_all[chan] ? daq_grant : invol_grant) begin
					invol_req <= 1'b0;
					daq_req <= 1'b0;
					if (!valid_v[chan])
						state <= IDLE;	// frame overwritten while waiting
					else if (report_all[chan])
						state <= DAQ_HEADER;
					else
						state <= PRM_CHANNEL;
				end
			end
			PRM_CHANNEL: begin
				param_write <= 1'b1;
				state <= PRM_TIME;
			end
			PRM_TIME: state <= PRM_DATA;
			PRM_DATA: state <= PRM_BITS;
			PRM_BITS: begin
				ack_q[chan] <= 1'b1;
				state <= PRM_DONE;
			end
			PRM_DONE: begin
				param_write <= 1'b0;
				cmd_done <= 1'b1;	// closes the response
				state <= IDLE;
			end
			DAQ_HEADER: begin
				daq_valid <= 1'b1;
				state <= DAQ_DATA;
			end
			DAQ_DATA: begin
				daq_valid <= 1'b1;
				ack_q[chan] <= 1'b1;
				state <= DAQ_TIME;
			end
			DAQ_TIME: begin
				daq_valid <= 1'b1;
				daq_end <= 1'b1;
				state <= IDLE;
			end
			default: state <= IDLE;
			endcase
		end
	end

	// one output register feeds both buses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			param_data <= '0;
		end else begin
			case (state)
			PRM_CHANNEL: param_data <= param_t'(chan);
			PRM_TIME: param_data <= param_t'(start_v[chan]);
			PRM_DATA: param_data <= param_t'(data_v[chan]);
			PRM_BITS: param_data <= param_t'(bits_v[chan]);
			PRM_DONE: param_data <= param_t'(RSP_DRO_DATA);
			DAQ_HEADER: param_data <= {1'b0, DAQT_DRO_DATA, 8'(chan), 16'h0000};
			DAQ_DATA: param_data <= param_t'(data_v[chan]);
			DAQ_TIME: param_data <= param_t'(start_v[chan]);
			default: ;
			endcase
		end
	end

	assign daq_data = param_data[31:0];

endmodule

/* verilog/dro_top.sv */
`timescale 1ns/1ps

module dro_top (
	input logic clk,
	input logic rst_n,
	input dro_pkg::word_t systime,

	input dro_pkg::cmd_t cmd,
	input logic cmd_ready,
	input dro_pkg::word_t arg_data,
	output logic cmd_done,

	output dro_pkg::param_t param_data,
	output logic param_write,
	output logic invol_req,
	input logic invol_grant,

	output dro_pkg::word_t daq_data,
	output logic daq_valid,
	output logic daq_end,
	output logic daq_req,
	input logic daq_grant,

	input logic [dro_pkg::DRO_CHANNELS-1:0] dro_clk,
	input logic [dro_pkg::DRO_CHANNELS-1:0] dro_do
);
	import dro_pkg::*;

	dro_report_if rpt [DRO_CHANNELS] ();

	timeout_t timeout [DRO_CHANNELS];
	logic [DRO_CHANNELS-1:0] report_all;
	logic [DRO_CHANNELS-1:0] clk_f;
	logic [DRO_CHANNELS-1:0] do_f;

	// ======================================================================
	// per channel front end
	// ======================================================================
	for (genvar i = 0; i < DRO_CHANNELS; i++) begin : g_chan
		dro_input_filter u_filter (
			.clk (clk),
			.rst_n (rst_n),
			.dro_clk (dro_clk[i]),
			.dro_do (dro_do[i]),
			.clk_f (clk_f[i]),
			.do_f (do_f[i])
		);

		dro_frame_decoder u_decoder (
			.clk (clk),
			.rst_n (rst_n),
			.systime (systime),
			.clk_f (clk_f[i]),
			.do_f (do_f[i]),
			.timeout (timeout[i]),
			.report_all (report_all[i]),
			.rpt (rpt[i])
		);
	end

	dro_reporter u_reporter (
		.clk (clk),
		.rst_n (rst_n),
		.cmd (cmd),
		.cmd_ready (cmd_ready),
		.arg_data (arg_data),
		.cmd_done (cmd_done),
		.param_data (param_data),
		.param_write (param_write),
		.invol_req (invol_req),
		.invol_grant (invol_grant),
		.daq_data (daq_data),
		.daq_valid (daq_valid),
		.daq_end (daq_end),
		.daq_req (daq_req),
		.daq_grant (daq_grant),
		.timeout (timeout),
		.report_all (report_all),
		.rpt (rpt)
	);

endmodule
